//--- cmd_pkg.sv
/*
  Command and datapath definitions for the arithmetic coprocessor.
  Holds the operand width, the tag width, the stream field widths and
  the opcode set that the decode, execute and capture blocks share.
*/
package cmd_pkg;

    // Width of each operand and of the result
    localparam int data_width = 32;

    // Tag that the host attaches to a command and gets back with the result
    localparam int tag_width = 8;

    // The stream user field holds the opcode on the command path and the zero flag on the way back
    localparam int opcode_bits = 3;
    localparam int flag_bits = 1;

    // Only the low bits of operand b take part in a left shift
    localparam int shift_bits = $clog2(data_width);

    // Values 6 and 7 are not defined and are refused at the bus
    typedef enum logic [opcode_bits-1:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_shl = 3'd5
    } opcode_t;

endpackage

//--- regmap_pkg.sv
/*
  Host register map of the coprocessor as seen over APB.
  Register offsets, command word fields, status bits and the
  states of the APB slave sequence.
*/
package regmap_pkg;

    localparam logic [7:0] addr_operand_a  = 8'h00;
    localparam logic [7:0] addr_operand_b  = 8'h04;
    localparam logic [7:0] addr_command    = 8'h08;
    localparam logic [7:0] addr_status     = 8'h0C;
    localparam logic [7:0] addr_result     = 8'h10;
    localparam logic [7:0] addr_result_tag = 8'h14;

    // The command word carries the opcode in the low bits and the tag in the second byte
    localparam int cmd_opcode_lsb = 0;
    localparam int cmd_opcode_msb = 2;
    localparam int cmd_tag_lsb = 8;
    localparam int cmd_tag_msb = 15;

    localparam int status_busy_bit = 0;
    localparam int status_done_bit = 1;
    localparam int status_zero_bit = 2;

    typedef enum logic [1:0] {st_idle, st_setup, st_access} apb_state_t;

endpackage

//--- stream_if.sv
/*
  Valid/ready stream with data, user and dest fields.
  The source drives the fields and valid, the sink drives ready.
  An item moves on a cycle where valid and ready are both high,
  and the source keeps valid and the fields steady until then.
*/
`timescale 1ns/1ns

interface stream_if #(
    parameter int data_bits = 32,
    parameter int user_bits = 1,
    parameter int dest_bits = 1
) ();

    logic [data_bits-1:0] data;
    logic [user_bits-1:0] user;
    logic [dest_bits-1:0] dest;
    logic valid;
    logic ready;

    modport source (output data, user, dest, valid, input ready);
    modport sink (input data, user, dest, valid, output ready);

endinterface

//--- result_if.sv
/*
  Link from the result holder to the APB slave.
  The provider reports the held result, tag, zero flag and done bit
  and pulses captured when a new result lands. The requester pulses
  clear_done once the host has read the result register.
*/
`timescale 1ns/1ns

interface result_if #(
    parameter int data_width = cmd_pkg::data_width
) ();

    logic [data_width-1:0] result;
    logic [cmd_pkg::tag_width-1:0] tag;
    logic zero;
    logic done;
    logic captured;
    logic clear_done;

    modport provider (output result, tag, zero, done, captured, input clear_done);
    modport requester (input result, tag, zero, done, captured, output clear_done);

endinterface

//--- apb_decode.sv
/*
  APB slave of the coprocessor in the clock_in domain.
  Holds both operands, launches a command onto the command stream on a
  write to the command register and tracks busy until the result is
  captured. Every transfer has one wait state. Errors are reported for
  unmapped offsets, illegal opcodes and commands written while busy.
*/
`timescale 1ns/1ns

module apb_decode #(
    parameter int data_width = cmd_pkg::data_width
) (
    input  logic                  clock_in,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [7:0]            paddr,
    input  logic [data_width-1:0] pwdata,
    output logic [data_width-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    stream_if.source              cmd,
    result_if.requester           res
);

    regmap_pkg::apb_state_t state;
    logic [data_width-1:0] operand_a;
    logic [data_width-1:0] operand_b;
    logic [cmd_pkg::opcode_bits-1:0] last_opcode;
    logic [cmd_pkg::tag_width-1:0] last_tag;
    logic [cmd_pkg::opcode_bits-1:0] wr_opcode;
    logic [data_width-1:0] read_word;
    logic busy;
    logic addr_mapped;
    logic cmd_rejected;
    logic access_start;
    logic write_ok;
    logic launch;

    assign wr_opcode = pwdata[regmap_pkg::cmd_opcode_msb:regmap_pkg::cmd_opcode_lsb];

    always_comb begin
        addr_mapped = 1'b1;
        read_word = '0;
        case (paddr)
            regmap_pkg::addr_operand_a: read_word = operand_a;
            regmap_pkg::addr_operand_b: read_word = operand_b;
            regmap_pkg::addr_command: begin
                read_word[regmap_pkg::cmd_opcode_msb:regmap_pkg::cmd_opcode_lsb] = last_opcode;
                read_word[regmap_pkg::cmd_tag_msb:regmap_pkg::cmd_tag_lsb] = last_tag;
            end
            regmap_pkg::addr_status: begin
                read_word[regmap_pkg::status_busy_bit] = busy;
                read_word[regmap_pkg::status_done_bit] = res.done;
                read_word[regmap_pkg::status_zero_bit] = res.zero;
            end
            regmap_pkg::addr_result: read_word = res.result;
            regmap_pkg::addr_result_tag: read_word[cmd_pkg::tag_width-1:0] = res.tag;
            default: addr_mapped = 1'b0;
        endcase
    end

    // A command is refused while one is in flight or when its opcode is undefined
    assign cmd_rejected = pwrite && (paddr == regmap_pkg::addr_command) &&
                          (busy || (wr_opcode > cmd_pkg::op_shl));

    // First access cycle, where the response is prepared for the wait state that follows
    assign access_start = (state == regmap_pkg::st_setup) && psel && penable;

    assign pready = (state == regmap_pkg::st_access);
    assign write_ok = pready && pwrite && !pslverr;
    assign launch = write_ok && (paddr == regmap_pkg::addr_command);
    assign res.clear_done = pready && !pwrite && (paddr == regmap_pkg::addr_result);

    always_ff @(posedge clock_in) begin
        if (!reset) begin
            state <= regmap_pkg::st_idle;
            pslverr <= 1'b0;
        end else begin
            case (state)
                regmap_pkg::st_idle: begin
                    if (psel && !penable) begin
                        state <= regmap_pkg::st_setup;
                    end
                end
                regmap_pkg::st_setup: begin
                    if (access_start) begin
                        state <= regmap_pkg::st_access;
                        pslverr <= !addr_mapped || cmd_rejected;
                    end else begin
                        state <= regmap_pkg::st_idle;
                    end
                end
                default: begin
                    state <= regmap_pkg::st_idle;
                    pslverr <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clock_in) begin
        if (access_start) begin
            prdata <= read_word;
        end
    end

    // Operands and the launched command fields
    always_ff @(posedge clock_in) begin
        if (write_ok && (paddr == regmap_pkg::addr_operand_a)) begin
            operand_a <= pwdata;
        end
        if (write_ok && (paddr == regmap_pkg::addr_operand_b)) begin
            operand_b <= pwdata;
        end
        if (launch) begin
            last_opcode <= wr_opcode;
            last_tag <= pwdata[regmap_pkg::cmd_tag_msb:regmap_pkg::cmd_tag_lsb];
            cmd.data <= {operand_a, operand_b};
            cmd.user <= wr_opcode;
            cmd.dest <= pwdata[regmap_pkg::cmd_tag_msb:regmap_pkg::cmd_tag_lsb];
        end
    end

    // Busy spans the whole round trip, not only the time valid waits for the crossing
    always_ff @(posedge clock_in) begin
        if (!reset) begin
            busy <= 1'b0;
            cmd.valid <= 1'b0;
        end else if (launch) begin
            busy <= 1'b1;
            cmd.valid <= 1'b1;
        end else begin
            if (cmd.valid && cmd.ready) begin
                cmd.valid <= 1'b0;
            end
            if (res.captured) begin
                busy <= 1'b0;
            end
        end
    end

    penable_needs_psel: assert property (
        @(posedge clock_in) disable iff (!reset) penable |-> psel
    );

endmodule

//--- stream_cdc.sv
/*
  Handshake crossing of one stream item between two clocks.
  The source side captures an item and toggles a request that is
  synchronized into the destination, where the held fields are shown
  with valid until taken. An acknowledge toggle then returns through
  its own synchronizer and frees the source for the next item.
  sync_stages must be 2 or more.
*/
`timescale 1ns/1ns

module stream_cdc #(
    parameter int data_bits   = 32,
    parameter int user_bits   = 1,
    parameter int dest_bits   = 1,
    parameter int sync_stages = 2
) (
    input logic      reset,
    input logic      clock_in,
    input logic      clock_out,
    stream_if.sink   in,
    stream_if.source out
);

    logic [data_bits-1:0] data_q;
    logic [user_bits-1:0] user_q;
    logic [dest_bits-1:0] dest_q;
    logic req_toggle;
    logic ack_toggle;
    logic req_seen;
    logic [sync_stages-1:0] req_sync;
    logic [sync_stages-1:0] ack_sync;
    logic take_in;
    logic take_req;

    assign take_in = in.valid && in.ready;

    // Source side, clocked by clock_in
    always_ff @(posedge clock_in) begin
        if (!reset) begin
            in.ready <= 1'b1;
            req_toggle <= 1'b0;
            ack_sync <= '0;
        end else begin
            ack_sync <= {ack_sync[sync_stages-2:0], ack_toggle};
            if (take_in) begin
                in.ready <= 1'b0;
                req_toggle <= ~req_toggle;
            end else if (!in.ready && (ack_sync[sync_stages-1] == req_toggle)) begin
                // The acknowledge has caught up with the request
                in.ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (take_in) begin
            data_q <= in.data;
            user_q <= in.user;
            dest_q <= in.dest;
        end
    end

    // A new request shows up as a difference between the synchronized toggle and the last one seen
    assign take_req = !out.valid && (req_sync[sync_stages-1] != req_seen);

    // Destination side, clocked by clock_out
    always_ff @(posedge clock_out) begin
        if (!reset) begin
            req_sync <= '0;
            req_seen <= 1'b0;
            ack_toggle <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            req_sync <= {req_sync[sync_stages-2:0], req_toggle};
            if (out.valid && out.ready) begin
                out.valid <= 1'b0;
                ack_toggle <= ~ack_toggle;
            end else if (take_req) begin
                out.valid <= 1'b1;
                req_seen <= ~req_seen;
            end
        end
    end

    // The held fields are steady by now since the request only moves after they were written
    always_ff @(posedge clock_out) begin
        if (take_req) begin
            out.data <= data_q;
            out.user <= user_q;
            out.dest <= dest_q;
        end
    end

    // The source must not reload its holding register before the destination has taken the item
    held_fields_stable: assert property (
        @(posedge clock_out) disable iff (!reset)
        out.valid |-> ({out.data, out.user, out.dest} == {data_q, user_q, dest_q})
    );

endmodule

//--- alu_execute.sv
/*
  Arithmetic unit in the clock_out domain.
  Takes one command from the command stream, computes the result and
  its zero flag and offers them with the command tag on the result
  stream one cycle later. No new command is taken until the result
  has been handed on.
*/
`timescale 1ns/1ns

module alu_execute #(
    parameter int data_width = cmd_pkg::data_width
) (
    input logic      clock_in,
    input logic      reset,
    stream_if.sink   cmd,
    stream_if.source res
);

    logic [data_width-1:0] operand_a;
    logic [data_width-1:0] operand_b;
    logic [data_width-1:0] result_next;
    cmd_pkg::opcode_t opcode;
    logic accept;

    // Operand a sits in the upper half of the command data
    assign operand_a = cmd.data[2*data_width-1:data_width];
    assign operand_b = cmd.data[data_width-1:0];
    assign opcode = cmd_pkg::opcode_t'(cmd.user);

    assign cmd.ready = !res.valid;
    assign accept = cmd.valid && cmd.ready;

    always_comb begin
        case (opcode)
            cmd_pkg::op_add: result_next = operand_a + operand_b;
            cmd_pkg::op_sub: result_next = operand_a - operand_b;
            cmd_pkg::op_and: result_next = operand_a & operand_b;
            cmd_pkg::op_or:  result_next = operand_a | operand_b;
            cmd_pkg::op_xor: result_next = operand_a ^ operand_b;
            cmd_pkg::op_shl: result_next = operand_a << operand_b[cmd_pkg::shift_bits-1:0];
            default:         result_next = '0;
        endcase
    end

    always_ff @(posedge clock_in) begin
        if (!reset) begin
            res.valid <= 1'b0;
        end else if (accept) begin
            res.valid <= 1'b1;
        end else if (res.valid && res.ready) begin
            res.valid <= 1'b0;
        end
    end

    always_ff @(posedge clock_in) begin
        if (accept) begin
            res.data <= result_next;
            res.user <= (result_next == '0);
            res.dest <= cmd.dest;
        end
    end

    result_held: assert property (
        @(posedge clock_in) disable iff (!reset)
        res.valid && !res.ready |=> res.valid && $stable(res.data)
    );

endmodule

//--- result_capture.sv
/*
  Holder of the returned result in the clock_in domain.
  Always ready. Stores result, tag and zero flag as they arrive,
  sets done and pulses captured, and drops done when the host has
  read the result register.
*/
`timescale 1ns/1ns

module result_capture #(
    parameter int data_width = cmd_pkg::data_width
) (
    input logic        clock_in,
    input logic        reset,
    stream_if.sink     res,
    result_if.provider status
);

    logic [data_width-1:0] result_q;
    logic take;

    assign res.ready = 1'b1;
    assign take = res.valid && res.ready;
    assign status.captured = take;
    assign status.result = result_q;

    always_ff @(posedge clock_in) begin
        if (take) begin
            result_q <= res.data;
            status.tag <= res.dest;
        end
    end

    // Done and the zero flag feed the status register of the APB slave
    always_ff @(posedge clock_in) begin
        if (!reset) begin
            status.done <= 1'b0;
            status.zero <= 1'b0;
        end else if (take) begin
            status.done <= 1'b1;
            status.zero <= res.user[0];
        end else if (status.clear_done) begin
            status.done <= 1'b0;
        end
    end

endmodule

//--- alu_cdc_top.sv
/*
  Top level of the two-clock arithmetic coprocessor.
  The host talks APB on clock_in. Commands cross to the clock_out
  domain for execution and the results cross back to be read.
  Both domains sample the same active-low synchronous reset.
*/
`timescale 1ns/1ns

module alu_cdc_top #(
    parameter int data_width  = cmd_pkg::data_width,
    parameter int sync_stages = 2
) (
    input  logic                  clock_in,
    input  logic                  clock_out,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [7:0]            paddr,
    input  logic [data_width-1:0] pwdata,
    output logic [data_width-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr
);

    // Command path carries both operands, the opcode and the tag
    stream_if #(
        .data_bits(2*data_width),
        .user_bits(cmd_pkg::opcode_bits),
        .dest_bits(cmd_pkg::tag_width)
    ) cmd_src (), cmd_dst ();

    // Result path carries the result, the zero flag and the tag
    stream_if #(
        .data_bits(data_width),
        .user_bits(cmd_pkg::flag_bits),
        .dest_bits(cmd_pkg::tag_width)
    ) res_src (), res_dst ();

    result_if #(.data_width(data_width)) status_bus ();

    apb_decode #(.data_width(data_width)) apb_decode_i (
        .clock_in(clock_in),
        .reset(reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .cmd(cmd_src),
        .res(status_bus)
    );

    stream_cdc #(
        .data_bits(2*data_width),
        .user_bits(cmd_pkg::opcode_bits),
        .dest_bits(cmd_pkg::tag_width),
        .sync_stages(sync_stages)
    ) cmd_cdc_i (
        .reset(reset),
        .clock_in(clock_in),
        .clock_out(clock_out),
        .in(cmd_src),
        .out(cmd_dst)
    );

    alu_execute #(.data_width(data_width)) alu_execute_i (
        .clock_in(clock_out),
        .reset(reset),
        .cmd(cmd_dst),
        .res(res_src)
    );

    // The return crossing runs the other way, from clock_out back to clock_in
    stream_cdc #(
        .data_bits(data_width),
        .user_bits(cmd_pkg::flag_bits),
        .dest_bits(cmd_pkg::tag_width),
        .sync_stages(sync_stages)
    ) res_cdc_i (
        .reset(reset),
        .clock_in(clock_out),
        .clock_out(clock_in),
        .in(res_src),
        .out(res_dst)
    );

    result_capture #(.data_width(data_width)) result_capture_i (
        .clock_in(clock_in),
        .reset(reset),
        .res(res_dst),
        .status(status_bus)
    );

endmodule

//--- tb_alu_cdc.sv
/*
  Testbench for the two-clock arithmetic coprocessor.
  Reads commands and expected results from alu_trace.txt, drives them
  over APB and checks result, tag, status bits and error responses.
  Trace kind 0 is a plain command, kind 1 adds a second command write
  while busy, kind 2 is an illegal opcode that must be refused.
*/
`timescale 1ns/1ns

module tb_alu_cdc;

    localparam int pready_limit = 20;
    localparam int poll_limit = 60;
    localparam int quiet_reads = 8;

    logic clock_in;
    logic clock_out;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [7:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;

    int errors;
    int failures;
    logic timed_out;

    alu_cdc_top #(.data_width(32), .sync_stages(2)) alu_cdc_top_i (
        .clock_in(clock_in),
        .clock_out(clock_out),
        .reset(reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr)
    );

    always #2 clock_in = ~clock_in;
    always #3 clock_out = ~clock_out;

    task automatic finish_run();
        $display("Closing count: %0d value errors, %0d other failures", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            errors++;
        end
    endtask

    // One APB transfer with setup, access and the single wait state
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int cycles;
        cycles = 0;
        @(posedge clock_in);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clock_in);
        #1;
        penable = 1'b1;
        @(posedge clock_in);
        #1;
        while (!pready && cycles < pready_limit) begin
            @(posedge clock_in);
            #1;
            cycles++;
        end
        if (!pready) begin
            $display("APB transfer to address 0x%02h never saw pready", addr);
            failures++;
            timed_out = 1'b1;
        end
        rdata = prdata;
        err = pslverr;
        // The transfer completes on this edge
        @(posedge clock_in);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic wait_done(output logic [31:0] status);
        int polls;
        logic err;
        polls = 0;
        apb_read(regmap_pkg::addr_status, status, err);
        while (!status[regmap_pkg::status_done_bit] && polls < poll_limit && !timed_out) begin
            apb_read(regmap_pkg::addr_status, status, err);
            polls++;
        end
        if (!status[regmap_pkg::status_done_bit]) begin
            $display("Status done never rose after a command was launched");
            failures++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_line(input logic [31:0] kind, input logic [31:0] op,
                            input logic [31:0] a, input logic [31:0] b, input logic [31:0] tag,
                            input logic [31:0] expected, input logic [31:0] zero);
        logic [31:0] command;
        logic [31:0] data;
        logic err;
        command = {16'h0, tag[7:0], 5'b0, op[2:0]};
        apb_write(regmap_pkg::addr_operand_a, a, err);
        check_value("pslverr on operand a", {31'b0, err}, 32'h0);
        apb_write(regmap_pkg::addr_operand_b, b, err);
        check_value("pslverr on operand b", {31'b0, err}, 32'h0);
        apb_read(regmap_pkg::addr_operand_a, data, err);
        check_value("operand a", data, a);
        apb_read(regmap_pkg::addr_operand_b, data, err);
        check_value("operand b", data, b);
        apb_write(regmap_pkg::addr_command, command, err);
        if (kind == 2) begin
            check_value("pslverr on illegal opcode", {31'b0, err}, 32'h1);
            apb_read(regmap_pkg::addr_status, data, err);
            check_value("status after illegal opcode", data, 32'h0);
        end else begin
            check_value("pslverr on command", {31'b0, err}, 32'h0);
            if (kind == 1) begin
                // A second command right behind the first meets busy
                apb_write(regmap_pkg::addr_command, command ^ 32'h0000_8000, err);
                check_value("pslverr on command while busy", {31'b0, err}, 32'h1);
            end
            // The register keeps the launched command even after a refused write
            apb_read(regmap_pkg::addr_command, data, err);
            check_value("command register", data, command);
            wait_done(data);
            check_value("status busy", {31'b0, data[regmap_pkg::status_busy_bit]}, 32'h0);
            check_value("status zero", {31'b0, data[regmap_pkg::status_zero_bit]}, zero);
            apb_read(regmap_pkg::addr_result_tag, data, err);
            check_value("result tag", data, {24'h0, tag[7:0]});
            apb_read(regmap_pkg::addr_result, data, err);
            check_value("result", data, expected);
            apb_read(regmap_pkg::addr_status, data, err);
            check_value("status done after result read",
                        {31'b0, data[regmap_pkg::status_done_bit]}, 32'h0);
            if (kind == 1) begin
                // The dropped command must not bring back a result of its own
                repeat (quiet_reads) begin
                    apb_read(regmap_pkg::addr_status, data, err);
                    check_value("status done from dropped command",
                                {31'b0, data[regmap_pkg::status_done_bit]}, 32'h0);
                end
            end
        end
    endtask

    initial begin
        int fd;
        int fields;
        int code;
        int lines_run;
        string line;
        logic [31:0] kind, op, a, b, tag, expected, zero;
        logic [31:0] data;
        logic err;

        errors = 0;
        failures = 0;
        timed_out = 1'b0;
        lines_run = 0;
        clock_in = 1'b0;
        clock_out = 1'b0;
        reset = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 8'h0;
        pwdata = 32'h0;

        repeat (5) @(posedge clock_in);
        #1;
        reset = 1'b1;

        // First access after reset
        apb_read(regmap_pkg::addr_status, data, err);
        check_value("status after reset", data, 32'h0);
        check_value("pslverr after reset", {31'b0, err}, 32'h0);

        apb_read(8'h18, data, err);
        check_value("pslverr on unmapped read", {31'b0, err}, 32'h1);
        check_value("prdata on unmapped read", data, 32'h0);
        apb_write(8'h20, 32'h1234_5678, err);
        check_value("pslverr on unmapped write", {31'b0, err}, 32'h1);

        fd = $fopen("alu_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file alu_trace.txt");
            failures++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h",
                                     kind, op, a, b, tag, expected, zero);
                    if (fields == 7) begin
                        run_line(kind, op, a, b, tag, expected, zero);
                        lines_run++;
                    end
                end
            end
            $fclose(fd);
            if (lines_run == 0 && !timed_out) begin
                $display("The trace file held no command lines");
                failures++;
            end
        end
        finish_run();
    end

endmodule

//--- alu_trace.txt
# kind opcode operand_a operand_b tag expected_result expected_zero, all hex
# kind 0 plain command, 1 command plus a second write while busy, 2 illegal opcode
0 0 00000001 00000002 01 00000003 0
0 0 ffffffff 00000001 02 00000000 1
0 0 7fffffff 00000001 03 80000000 0
0 1 00000010 00000003 04 0000000d 0
0 1 12345678 12345678 05 00000000 1
0 1 00000000 00000001 06 ffffffff 0
0 2 f0f0f0f0 0ff00ff0 07 00f000f0 0
0 2 aaaaaaaa 55555555 08 00000000 1
0 3 f0000000 0000000f 09 f000000f 0
0 3 00000000 00000000 0a 00000000 1
0 4 a5a5a5a5 ffffffff 0b 5a5a5a5a 0
0 4 deadbeef deadbeef 0c 00000000 1
0 5 00000001 0000001f 0d 80000000 0
0 5 00000003 00000024 0e 00000030 0
0 5 80000000 00000001 0f 00000000 1
1 0 00000100 00000200 10 00000300 0
1 4 0000ffff 0000ff00 11 000000ff 0
2 6 00000001 00000001 12 00000000 0
2 7 00000000 00000000 13 00000000 0
0 1 00000005 00000007 14 fffffffe 0
0 0 00000000 00000000 ff 00000000 1

//--- sim.f
cmd_pkg.sv
regmap_pkg.sv
stream_if.sv
result_if.sv
apb_decode.sv
stream_cdc.sv
alu_execute.sv
result_capture.sv
alu_cdc_top.sv
tb_alu_cdc.sv
